/* include/cmp_rx_config.svh */
`ifndef CMP_RX_CONFIG_SVH
`define CMP_RX_CONFIG_SVH

// ----------------------------------------
// Lane and frame geometry
// ----------------------------------------
`define CMP_WORD_W        16      // One 8b10b decoded word per CMP_RX_CLK160
`define CMP_FRAME_WORDS   4       // K word plus three data words
`define CMP_FRAME_DATA_W  48      // Data words 3..1 packed together

// ----------------------------------------
// K word code fields
// ----------------------------------------
// Low byte bits 4..1 equal E for every frame K word
// Allowed K bytes are 1C 3C 5C 7C 9C BC DC FC
`define CMP_K_CODE        4'hE
`define CMP_LT_K          8'hFC   // K byte that also asks for the latency trigger

// ----------------------------------------
// Link monitor limits
// ----------------------------------------
`define CMP_GOOD_RUN      16      // Good frames in a row before link is good
`define CMP_ERR_W         8       // Error counter width
`define CMP_ERR_SAT       8'd254  // Error counter stops here
`define CMP_BAD_THRESH    8'd127  // Link bad while count is above this

`endif

/* logic/cmp_rx_pkg.sv */
`include "cmp_rx_config.svh"

package cmp_rx_pkg;

  // ----------------------------------------
  // Lane word from the transceiver
  // ----------------------------------------
  // One decoded word per clock with its 8b10b status bits
  typedef struct packed {
    logic [`CMP_WORD_W-1:0] data;        // Two decoded bytes
    logic [1:0]             isk;         // K flag per byte, bit 0 is the low byte
    logic [1:0]             notintable;  // Code not in 8b10b table
    logic                   lossofsync;  // Upper loss-of-sync status bit
  } lane_word_t;

  // ----------------------------------------
  // Assembled frame
  // ----------------------------------------
  typedef struct packed {
    logic [`CMP_FRAME_DATA_W-1:0] data;  // Word 3 on top, word 1 at the bottom
    logic [`CMP_WORD_W-1:0]       kchar; // K word that opened the frame
    logic [3:1]                   nonzero; // One flag per data word
    logic                         ltncy_trig; // K byte asked for a latency trigger
  } rx_frame_t;

  // ----------------------------------------
  // Link monitor status
  // ----------------------------------------
  typedef struct packed {
    logic                  good;      // Run of good frames reached
    logic                  had_err;   // Link dropped at least once or never came up
    logic                  bad;       // Error count past threshold
    logic [`CMP_ERR_W-1:0] errcount;  // Saturating error count
  } link_status_t;

  // Widths used by the frame format
  // 21 bits per lane word
  // 68 bits per frame
  // 11 bits of status

endpackage

/* logic/frame_phase.sv */
`timescale 1ns/1ns
`include "cmp_rx_config.svh"

// Frame phase tracking
// The K word marks word 0 and the three data strobes follow it

module frame_phase (
  input  logic                   CMP_RX_CLK160,
  input  logic                   cmp_rx_resetdone,
  input  cmp_rx_pkg::lane_word_t lane,
  output logic                   k_seen,   // K word on the lane this cycle
  output logic                   cew1,     // Data word 1 on the lane
  output logic                   cew2,     // Data word 2 on the lane
  output logic                   cew3,     // Data word 3 on the lane
  output cmp_rx_pkg::lane_word_t k_word    // K word of the frame in flight
);

  logic k_flag_ok;  // K flag on the low byte only
  logic k_code_ok;  // Low byte carries the frame K code

  // ----------------------------------------
  // K word detect
  // ----------------------------------------
  assign k_flag_ok = (lane.isk == 2'b01);
  assign k_code_ok = (lane.data[4:1] == `CMP_K_CODE);
  assign k_seen    = k_flag_ok && k_code_ok;  // Combinational, same cycle as the K word

  // ----------------------------------------
  // Word strobe chain
  // ----------------------------------------
  // Plain delay of k_seen
  // A K word inside a frame starts a second chain that overlaps the first
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      cew1 <= 1'b0;
      cew2 <= 1'b0;
      cew3 <= 1'b0;
    end else begin
      cew1 <= k_seen;  // First data word follows the K word
      cew2 <= cew1;
      cew3 <= cew2;    // Last word of the frame
    end
  end

  // ----------------------------------------
  // K word hold
  // ----------------------------------------
  // Kept for kchar and the latency trigger at cew3
  always_ff @(posedge CMP_RX_CLK160) begin
    if (k_seen) begin
      k_word <= lane;
    end
  end

endmodule

/* logic/frame_assembler.sv */
`timescale 1ns/1ns
`include "cmp_rx_config.svh"

// Frame assembly and per-word quality
// Frame goes out the cycle after cew3, four cycles after the K word

module frame_assembler (
  input  logic                   CMP_RX_CLK160,
  input  logic                   cmp_rx_resetdone,
  input  logic                   sync_clear,   // Sync lost or resync request
  input  cmp_rx_pkg::lane_word_t lane,
  input  logic                   k_seen,
  input  logic                   cew1,
  input  logic                   cew2,
  input  logic                   cew3,
  input  cmp_rx_pkg::lane_word_t k_word,
  output cmp_rx_pkg::rx_frame_t  frame,        // Zero outside frame_valid
  output logic                   frame_valid,  // One cycle per frame
  output logic                   frame_good    // All four words clean, no gap before
);

  logic [`CMP_WORD_W-1:0]      w1_q;      // Data word 1
  logic [`CMP_WORD_W-1:0]      w2_q;      // Data word 2
  logic [2:1]                  nz_q;      // Nonzero flags of words 1 and 2
  logic [`CMP_FRAME_WORDS-1:0] qual_q;    // One quality bit per frame word
  logic                        broken_q;  // Gap seen since the last frame
  logic                        gap;       // Cycle with no frame word at all
  logic                        k_ok;      // Lane holds a clean K word
  logic                        d_ok;      // Lane holds a clean data word

  // Transceiver status clean for this word
  function automatic logic link_clean(input cmp_rx_pkg::lane_word_t w);
    return !w.lossofsync && (w.notintable == 2'b00);
  endfunction

  // ----------------------------------------
  // Word judgement
  // ----------------------------------------
  assign k_ok = link_clean(lane);  // K flag and code already matched by k_seen
  assign d_ok = link_clean(lane) && (lane.isk == 2'b00);  // No K flag on data
  assign gap  = !(k_seen || cew1 || cew2 || cew3);        // Stream broken here

  // ----------------------------------------
  // Data word capture
  // ----------------------------------------
  always_ff @(posedge CMP_RX_CLK160) begin
    if (cew1) begin
      w1_q    <= lane.data;
      nz_q[1] <= |lane.data;
    end
    if (cew2) begin
      w2_q    <= lane.data;
      nz_q[2] <= |lane.data;
    end
  end

  // ----------------------------------------
  // Quality tracking and frame output
  // ----------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      qual_q      <= '0;
      broken_q    <= 1'b0;
      frame_valid <= 1'b0;
      frame       <= '0;
    end else if (sync_clear) begin
      qual_q      <= '0;
      broken_q    <= 1'b0;
      frame_valid <= 1'b0;
      frame       <= '0;
    end else begin
      // Each strobe records its own word
      if (k_seen) qual_q[0] <= k_ok;
      if (cew1)   qual_q[1] <= d_ok;
      if (cew2)   qual_q[2] <= d_ok;
      if (cew3)   qual_q[3] <= d_ok;

      // Gap spoils the next frame out
      if (gap) begin
        broken_q <= 1'b1;
      end else if (frame_valid) begin
        broken_q <= 1'b0;  // Reported with this frame
      end

      frame_valid <= cew3;
      if (cew3) begin
        frame.data       <= {lane.data, w2_q, w1_q};  // Word 3 arrives now
        frame.kchar      <= k_word.data;
        frame.nonzero    <= {|lane.data, nz_q};
        frame.ltncy_trig <= (k_word.data[7:0] == `CMP_LT_K);
      end else begin
        frame <= '0;  // Quiet between frames
      end
    end
  end

  // Reduce word quality into one bit per frame
  assign frame_good = frame_valid && (&qual_q) && !broken_q;

endmodule

/* logic/link_monitor.sv */
`timescale 1ns/1ns
`include "cmp_rx_config.svh"

// Link health monitor
// Judges the link from the frame quality stream and counts errors

module link_monitor (
  input  logic                     CMP_RX_CLK160,
  input  logic                     cmp_rx_resetdone,
  input  logic                     sync_clear,   // Sync lost or resync request
  input  logic                     frame_valid,
  input  logic                     frame_good,
  input  logic                     force_error,  // Asynchronous error injection
  output cmp_rx_pkg::link_status_t status
);

  localparam int RUN_W = $clog2(`CMP_GOOD_RUN + 1);  // Counts 0 to the run length

  logic [RUN_W-1:0]      run_q;       // Good frames in a row
  logic                  had_err_q;   // Sticky link-down flag
  logic [`CMP_ERR_W-1:0] err_q;       // Error counter
  logic [1:0]            force_sync;  // Two-stage synchronizer
  logic                  force_prev;  // Last synchronized value for edge detect
  logic                  good;
  logic                  link_down;
  logic                  err_inj;
  logic                  err_max;

  // ----------------------------------------
  // Link state decode
  // ----------------------------------------
  assign good      = (run_q == RUN_W'(`CMP_GOOD_RUN));  // Counter parks at run length
  assign link_down = frame_valid && !frame_good && good; // Was up and a bad frame came
  assign err_inj   = force_sync[1] && !force_prev;       // Rising edge of force_error
  assign err_max   = (err_q == `CMP_ERR_SAT);

  // ----------------------------------------
  // Forced error synchronizer
  // ----------------------------------------
  // Count lands two to three cycles after the input edge
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      force_sync <= 2'b00;
      force_prev <= 1'b0;
    end else begin
      force_sync <= {force_sync[0], force_error};
      force_prev <= force_sync[1];
    end
  end

  // ----------------------------------------
  // Run counter, sticky error, error count
  // ----------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      run_q     <= '0;
      had_err_q <= 1'b0;
      err_q     <= '0;
    end else if (sync_clear) begin
      run_q     <= '0;  // Run restarts after resync
      had_err_q <= 1'b0;
      err_q     <= '0;
    end else begin
      if (frame_valid) begin
        if (!frame_good) begin
          run_q <= '0;            // Any bad frame drops good
        end else if (!good) begin
          run_q <= run_q + 1'b1;  // Stops at the run length
        end
      end

      if (link_down) begin
        had_err_q <= 1'b1;  // Held until the next clear
      end

      // Injection and link loss together count once
      if ((err_inj || link_down) && !err_max) begin
        err_q <= err_q + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Status out
  // ----------------------------------------
  assign status.good     = good;
  assign status.had_err  = had_err_q || !good;  // Also set while never up
  assign status.bad      = (err_q > `CMP_BAD_THRESH);
  assign status.errcount = err_q;

endmodule

/* logic/cmp_fiber_rx.sv */
`timescale 1ns/1ns

// Comparator fiber receive decoder
// Decoded lane words in, frames and link status out

module cmp_fiber_rx (
  input  logic                     CMP_RX_CLK160,
  input  logic                     cmp_rx_resetdone,  // Transceiver reset done, active low reset
  input  cmp_rx_pkg::lane_word_t   lane,
  input  logic                     rx_sync_done,      // Phase alignment finished
  input  logic                     ttc_resync,        // Clears link monitor and frame state
  input  logic                     force_error,       // Error injection, any clock domain
  output cmp_rx_pkg::rx_frame_t    frame,
  output logic                     frame_valid,
  output cmp_rx_pkg::link_status_t status
);

  logic                   sync_clear;  // Shared synchronous clear
  logic                   k_seen;
  logic                   cew1;
  logic                   cew2;
  logic                   cew3;
  cmp_rx_pkg::lane_word_t k_word;
  logic                   frame_good;

  // ----------------------------------------
  // Clear condition
  // ----------------------------------------
  // Not synced yet or a resync from TTC
  assign sync_clear = !rx_sync_done || ttc_resync;

  // ----------------------------------------
  // Frame phase
  // ----------------------------------------
  frame_phase u_frame_phase (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .lane             (lane),
    .k_seen           (k_seen),
    .cew1             (cew1),
    .cew2             (cew2),
    .cew3             (cew3),
    .k_word           (k_word)
  );

  // ----------------------------------------
  // Frame assembly
  // ----------------------------------------
  frame_assembler u_frame_assembler (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .sync_clear       (sync_clear),
    .lane             (lane),
    .k_seen           (k_seen),
    .cew1             (cew1),
    .cew2             (cew2),
    .cew3             (cew3),
    .k_word           (k_word),
    .frame            (frame),
    .frame_valid      (frame_valid),
    .frame_good       (frame_good)   // Only the monitor sees quality
  );

  // ----------------------------------------
  // Link monitor
  // ----------------------------------------
  link_monitor u_link_monitor (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .sync_clear       (sync_clear),
    .frame_valid      (frame_valid),
    .frame_good       (frame_good),
    .force_error      (force_error),
    .status           (status)
  );

endmodule

/* tb/tb_cmp_fiber_rx.sv */
`timescale 1ns/1ns
`include "cmp_rx_config.svh"

module tb_cmp_fiber_rx;

  // ----------------------------------------
  // Run length and watchdog
  // ----------------------------------------
  localparam int CLK_NS        = 40;
  localparam int ASM_FRAMES    = 24;                      // Random back-to-back frames
  localparam int LT_FRAMES     = 4;
  localparam int UP_FRAMES     = `CMP_GOOD_RUN;
  localparam int LOSS_FRAMES   = 4 * `CMP_GOOD_RUN + 3;   // Three faults plus restart run
  localparam int PULSES        = 258;                     // Past saturation on purpose
  localparam int PULSE_CYCLES  = 8;                       // One pulse and its check
  localparam int MARGIN_CYCLES = 300;                     // Reset, resyncs, drains
  localparam int TOTAL_FRAMES  = ASM_FRAMES + LT_FRAMES + UP_FRAMES + LOSS_FRAMES;
  localparam int WATCHDOG_NS   = (TOTAL_FRAMES * 4 + PULSES * PULSE_CYCLES
                                  + MARGIN_CYCLES) * CLK_NS;

  // Fault kinds for send_frame
  localparam int FAULT_NONE  = 0;
  localparam int FAULT_NIT   = 1;  // Not-in-table on data word 2
  localparam int FAULT_KFLAG = 2;  // K flag on data word 2
  localparam int FAULT_GAP   = 3;  // Idle cycle before the K word

  logic                     CMP_RX_CLK160;
  logic                     cmp_rx_resetdone;
  cmp_rx_pkg::lane_word_t   lane;
  logic                     rx_sync_done;
  logic                     ttc_resync;
  logic                     force_error;
  cmp_rx_pkg::rx_frame_t    frame;
  logic                     frame_valid;
  cmp_rx_pkg::link_status_t status;

  cmp_rx_pkg::lane_word_t   word_q[$];        // Words waiting for the lane
  cmp_rx_pkg::rx_frame_t    exp_q[$];         // Frames expected at frame_valid
  cmp_rx_pkg::link_status_t status_after;     // Status after the last frame
  logic                     status_pending = 1'b0;
  int                       frames_done = 0;  // Frames seen at frame_valid
  logic                     resync_hold;      // Drive ttc_resync while lane idle
  integer                   seed = 32'h7cdb;

  cmp_fiber_rx u_dut (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .lane             (lane),
    .rx_sync_done     (rx_sync_done),
    .ttc_resync       (ttc_resync),
    .force_error      (force_error),
    .frame            (frame),
    .frame_valid      (frame_valid),
    .status           (status)
  );

  initial begin
    CMP_RX_CLK160 = 1'b0;
    forever #(CLK_NS / 2) CMP_RX_CLK160 = ~CMP_RX_CLK160;
  end

  // ----------------------------------------
  // Failure reporting and checks
  // ----------------------------------------
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [67:0] got,
                             input logic [67:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Bad follows from the count, had_err from the caller
  task automatic check_status(input cmp_rx_pkg::link_status_t got, input int good,
                              input int had_err, input int errcount);
    cmp_rx_pkg::link_status_t exp;
    exp.good     = (good != 0);
    exp.had_err  = (had_err != 0);
    exp.errcount = 8'(errcount);
    exp.bad      = (exp.errcount > `CMP_BAD_THRESH);
    check_equal("status", 68'(got), 68'(exp));
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic logic [15:0] random_word();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[15:0];
  endfunction

  // Any of the eight K bytes with code E in bits 4..1
  function automatic logic [7:0] random_k();
    logic [31:0] rnd;
    rnd = $random(seed);
    return {rnd[2:0], 5'b11100};
  endfunction

  // Queue one frame and its expected output
  task automatic send_frame(input logic [7:0] k_byte, input logic [15:0] w1,
                            input logic [15:0] w2, input logic [15:0] w3, input int fault);
    cmp_rx_pkg::lane_word_t k;
    cmp_rx_pkg::lane_word_t d1;
    cmp_rx_pkg::lane_word_t d2;
    cmp_rx_pkg::lane_word_t d3;
    cmp_rx_pkg::lane_word_t idle;
    cmp_rx_pkg::rx_frame_t  exp;
    k       = '0;
    d1      = '0;
    d2      = '0;
    d3      = '0;
    idle    = '0;
    k.data[7:0]  = k_byte;
    k.data[15:8] = 8'(random_word());  // High byte is plain data
    k.isk   = 2'b01;
    d1.data = w1;
    d2.data = w2;
    d3.data = w3;
    if (fault == FAULT_NIT) d2.notintable = 2'b01;
    if (fault == FAULT_KFLAG) d2.isk = 2'b10;
    if (fault == FAULT_GAP) word_q.push_back(idle);
    word_q.push_back(k);
    word_q.push_back(d1);
    word_q.push_back(d2);
    word_q.push_back(d3);
    exp.data       = {w3, w2, w1};             // Word 3 on top
    exp.kchar      = k.data;
    exp.nonzero    = {|w3, |w2, |w1};
    exp.ltncy_trig = (k_byte == `CMP_LT_K);
    exp_q.push_back(exp);
  endtask

  task automatic send_random_frame(input int fault);
    send_frame(random_k(), random_word(), random_word(), random_word(), fault);
  endtask

  task automatic wait_frames(input int target);
    while (frames_done < target) @(posedge CMP_RX_CLK160);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || status_pending) @(posedge CMP_RX_CLK160);
  endtask

  // Resync while idle, released as the next K word goes out
  task automatic resync_link();
    wait_drain();
    resync_hold = 1'b1;
    repeat (3) @(posedge CMP_RX_CLK160);
    resync_hold = 1'b0;
  endtask

  task automatic pulse_force_error();
    @(posedge CMP_RX_CLK160);
    #2 force_error = 1'b1;
    repeat (3) @(posedge CMP_RX_CLK160);
    #2 force_error = 1'b0;
    repeat (3) @(posedge CMP_RX_CLK160);  // Count lands in this window
  endtask

  // ----------------------------------------
  // Lane driver and frame monitor
  // ----------------------------------------
  initial begin : word_driver
    lane       = '0;
    ttc_resync = 1'b0;
    forever begin
      @(posedge CMP_RX_CLK160);
      #2;
      if (word_q.size() != 0) begin
        lane       = word_q.pop_front();
        ttc_resync = 1'b0;
      end else begin
        lane       = '0;           // Idle word breaks the stream
        ttc_resync = resync_hold;
      end
    end
  end

  always @(negedge CMP_RX_CLK160) begin : frame_monitor
    cmp_rx_pkg::rx_frame_t exp;
    if (status_pending) begin
      status_after   = status;     // Monitor has taken this frame by now
      frames_done    = frames_done + 1;
      status_pending = 1'b0;
    end
    if (frame_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected frame_valid at %0t ns with no frame sent", $time);
        abort_run();
      end
      exp = exp_q.pop_front();
      check_equal("frame", frame, exp);
      status_pending = 1'b1;
    end else begin
      check_equal("frame", frame, '0);  // Quiet between frames
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic frame_assembly();
    logic [15:0] w1;
    logic [15:0] w2;
    logic [15:0] w3;
    for (int i = 0; i < ASM_FRAMES; i++) begin
      w1 = random_word();
      w2 = random_word();
      w3 = random_word();
      if (i % 4 == 1) w1 = '0;
      if (i % 4 == 2) w2 = '0;
      if (i % 4 == 3) w3 = '0;
      if (i == ASM_FRAMES - 1) begin
        w1 = '0;
        w2 = '0;
        w3 = '0;
      end
      send_frame(random_k(), w1, w2, w3, FAULT_NONE);
    end
    wait_drain();
  endtask

  task automatic latency_trigger();
    send_frame(8'hFC, random_word(), random_word(), random_word(), FAULT_NONE);
    send_frame(8'hBC, random_word(), random_word(), random_word(), FAULT_NONE);
    send_frame(8'h1C, random_word(), random_word(), random_word(), FAULT_NONE);
    send_frame(8'hFC, random_word(), random_word(), random_word(), FAULT_NONE);
    wait_drain();
  endtask

  task automatic link_comes_up();
    int base;
    resync_link();
    base = frames_done;
    repeat (UP_FRAMES) send_random_frame(FAULT_NONE);
    wait_frames(base + UP_FRAMES - 1);
    check_status(status_after, 0, 1, 0);  // One frame short
    wait_frames(base + UP_FRAMES);
    check_status(status_after, 1, 0, 0);
    wait_drain();
  endtask

  task automatic link_loss();
    int base;
    resync_link();
    base = frames_done;
    repeat (16) send_random_frame(FAULT_NONE);
    send_random_frame(FAULT_NIT);
    repeat (16) send_random_frame(FAULT_NONE);
    send_random_frame(FAULT_KFLAG);
    repeat (16) send_random_frame(FAULT_NONE);
    send_random_frame(FAULT_GAP);
    wait_frames(base + 16);
    check_status(status_after, 1, 0, 0);
    wait_frames(base + 17);
    check_status(status_after, 0, 1, 1);
    wait_frames(base + 33);
    check_status(status_after, 1, 1, 1);  // had_err sticky while back up
    wait_frames(base + 34);
    check_status(status_after, 0, 1, 2);
    wait_frames(base + 50);
    check_status(status_after, 1, 1, 2);
    wait_frames(base + 51);
    check_status(status_after, 0, 1, 3);
    resync_link();
    base = frames_done;
    repeat (16) send_random_frame(FAULT_NONE);  // K word follows the resync directly
    @(negedge CMP_RX_CLK160);
    check_status(status, 0, 1, 0);        // Count cleared, run restarts
    wait_frames(base + 15);
    check_status(status_after, 0, 1, 0);
    wait_frames(base + 16);
    check_status(status_after, 1, 0, 0);
    wait_drain();
  endtask

  task automatic forced_error_count();
    int expected;
    resync_link();
    for (int i = 1; i <= PULSES; i++) begin
      pulse_force_error();
      expected = (i > int'(`CMP_ERR_SAT)) ? int'(`CMP_ERR_SAT) : i;
      @(negedge CMP_RX_CLK160);
      check_status(status, 0, 1, expected);  // bad from count 128 on
    end
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial begin
    cmp_rx_resetdone = 1'b0;
    rx_sync_done     = 1'b0;
    force_error      = 1'b0;
    resync_hold      = 1'b0;
    repeat (3) @(posedge CMP_RX_CLK160);
    #2 cmp_rx_resetdone = 1'b1;
    @(posedge CMP_RX_CLK160);
    #2 rx_sync_done = 1'b1;
    @(posedge CMP_RX_CLK160);
    frame_assembly();
    latency_trigger();
    link_comes_up();
    link_loss();
    forced_error_count();
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
    abort_run();
  end

endmodule

/* sources.f */
+incdir+include
logic/cmp_rx_pkg.sv
logic/frame_phase.sv
logic/frame_assembler.sv
logic/link_monitor.sv
logic/cmp_fiber_rx.sv
tb/tb_cmp_fiber_rx.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_cmp_fiber_rx
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
